//--- source/usbPe_defs.svh
`ifndef USBPE_DEFS_SVH
`define USBPE_DEFS_SVH

// ==================================================
// Engine limits
// ==================================================

// Endpoints 0 up to this number minus one answer to tokens
`define USB_PE_ENDPOINTS 4
// Largest number of data bytes sent in one IN packet
`define USB_PE_MAX_PACKET 8
// Cycles the engine waits for a host packet before it gives up
`define USB_PE_TIMEOUT 64

// ==================================================
// PID nibbles as they appear in the low half of a PID byte
// ==================================================
`define PID_OUT 4'h1
`define PID_IN 4'h9
`define PID_SOF 4'h5
`define PID_SETUP 4'hD
`define PID_ACK 4'h2
`define PID_NAK 4'hA
`define PID_STALL 4'hE
`define PID_DATA0 4'h3
`define PID_DATA1 4'hB

`endif

//--- source/usbPePkg.sv
`include "usbPe_defs.svh"

package usbPePkg;

    // One byte as it crosses the line receiver or transmitter
    typedef logic [7:0] byteT;

    // The PID itself without its check nibble
    typedef logic [3:0] pidT;

    // USB device addresses are seven bits wide
    typedef logic [6:0] devAddrT;

    // Endpoint numbers as carried by a token
    typedef logic [3:0] epNumT;

    // Must hold the full packet limit, so one extra value is needed
    typedef logic [$clog2(`USB_PE_MAX_PACKET + 1)-1:0] byteCountT;

    // Wait counter for host packets
    typedef logic [$clog2(`USB_PE_TIMEOUT + 1)-1:0] timerT;

    // Transaction controller states
    // OUT walks OUT_DATA, OUT_RESPOND, OUT_SEND
    // IN walks IN_RESPOND, IN_SEND, IN_AWAIT
    // Both end in FINISH, which closes the send handshake
    typedef enum logic [3:0] {
        IDLE,
        OUT_DATA,
        OUT_RESPOND,
        OUT_SEND,
        IN_RESPOND,
        IN_SEND,
        IN_AWAIT,
        FINISH
    } ctrlStateT;

endpackage

//--- source/tokenIf.sv
`timescale 1ns/1ps

// Results of every received packet, passed from the receive path to the controller
interface tokenIf;

    // Receiver side
    logic tokenValid;
    logic isIn;
    usbPePkg::epNumT epNum;
    logic rxDone;
    logic rxSuccess;
    usbPePkg::pidT rxPid;

    // Controller side
    // dataPhase sends the bytes after the PID to the endpoint
    logic dataPhase;
    // respPhase keeps a host reply from being taken as a new token
    logic respPhase;

    modport receiver (
        output tokenValid, isIn, epNum, rxDone, rxSuccess, rxPid,
        input dataPhase, respPhase
    );

    modport controller (
        input tokenValid, isIn, epNum, rxDone, rxSuccess, rxPid,
        output dataPhase, respPhase
    );

endinterface

//--- source/sendReqIf.sv
`timescale 1ns/1ps

// Four-phase send request between the controller and the packet sender
// The controller raises req with pid and withData stable
// The sender raises ack after the last byte went out
// req falls, then ack falls, and only then may req rise again
interface sendReqIf;

    logic req;
    // PID to send, the check nibble is added by the sender
    usbPePkg::pidT pid;
    // Endpoint bytes follow the PID when set
    logic withData;
    logic ack;

    modport controller (
        output req, pid, withData,
        input ack
    );

    modport sender (
        input req, pid, withData,
        output ack
    );

endinterface

//--- source/tokenReceiver.sv
`timescale 1ns/1ps
`include "usbPe_defs.svh"

module tokenReceiver (
    input logic clk12_i,
    input logic arstN_i,
    input usbPePkg::devAddrT devAddr_i,
    input usbPePkg::byteT rxData_i,
    input logic rxValid_i,
    input logic rxLast_i,
    input logic rxCrcOk_i,
    output logic rxAccept_o,
    output usbPePkg::byteT epOutData_o,
    output logic epOutValid_o,
    input logic epOutFull_i,
    output usbPePkg::epNumT epNum_o,
    tokenIf.receiver tok
);

    // Holds PID, address byte and the byte with the upper endpoint bits
    usbPePkg::byteT pktBuf [3];
    // Position of the next byte within the current packet that saturates at 3
    logic [1:0] byteIdx;
    usbPePkg::epNumT epNumQ;

    logic rxFire;
    logic lastFire;
    logic routeData;
    usbPePkg::pidT bufPid;
    usbPePkg::devAddrT tokAddr;
    usbPePkg::epNumT tokEp;
    logic isTokenPid;
    logic tokenOk;

    // ==================================================
    // Byte acceptance and endpoint routing
    // ==================================================

    assign rxFire = rxValid_i && rxAccept_o;
    assign lastFire = rxFire && rxLast_i;

    // In the data phase the PID byte is dropped and the rest goes to the endpoint
    assign routeData = tok.dataPhase && (byteIdx != 2'd0);

    // Only a full endpoint stalls the line. The last byte always gets through
    assign rxAccept_o = !(routeData && epOutFull_i) || rxLast_i;

    assign epOutData_o = rxData_i;
    // A last byte forced in while the endpoint is full is dropped here
    assign epOutValid_o = routeData && rxFire && !epOutFull_i;

    // ==================================================
    // Token decoding
    // ==================================================

    // Byte 2 is decoded straight from the line in the cycle it transfers
    assign bufPid = pktBuf[0][3:0];
    assign tokAddr = pktBuf[1][6:0];
    assign tokEp = {rxData_i[2:0], pktBuf[1][7]};

    // SOF and every non-token PID fall out here
    assign isTokenPid = (bufPid == `PID_OUT) || (bufPid == `PID_IN) || (bufPid == `PID_SETUP);

    // A token must be exactly three bytes, good, ours and for an endpoint that exists
    assign tokenOk = lastFire && !tok.dataPhase && !tok.respPhase && (byteIdx == 2'd2)
        && rxCrcOk_i && isTokenPid && (tokAddr == devAddr_i)
        && (tokEp < usbPePkg::epNumT'(`USB_PE_ENDPOINTS));

    // Only the first three bytes of a packet are kept
    always_ff @(posedge clk12_i) begin
        if (rxFire && !tok.dataPhase && (byteIdx != 2'd3)) begin
            pktBuf[byteIdx] <= rxData_i;
        end
    end

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            byteIdx <= 2'd0;
            epNumQ <= '0;
            tok.isIn <= 1'b0;
            tok.tokenValid <= 1'b0;
            tok.rxDone <= 1'b0;
            tok.rxSuccess <= 1'b0;
        end else begin
            tok.tokenValid <= tokenOk;
            tok.rxDone <= lastFire;
            if (lastFire) begin
                byteIdx <= 2'd0;
                // A last byte forced past a full endpoint fails the whole packet
                tok.rxSuccess <= rxCrcOk_i && !(routeData && epOutFull_i);
            end else if (rxFire) begin
                if (byteIdx != 2'd3) begin
                    byteIdx <= byteIdx + 2'd1;
                end
            end
            // The endpoint selection stays put until the next valid token
            if (tokenOk) begin
                epNumQ <= tokEp;
                tok.isIn <= bufPid == `PID_IN;
            end
        end
    end

    assign tok.epNum = epNumQ;
    assign tok.rxPid = bufPid;
    assign epNum_o = epNumQ;

    // A packet end with a PID outside OUT, IN and SETUP never starts a transaction
    ignoredPidNoToken: assert property (@(posedge clk12_i) disable iff (!arstN_i)
        (tok.rxDone && !(tok.rxPid inside {`PID_OUT, `PID_IN, `PID_SETUP})) |-> !tok.tokenValid);

endmodule

//--- source/transactionCtrl.sv
`timescale 1ns/1ps
`include "usbPe_defs.svh"

module transactionCtrl (
    input logic clk12_i,
    input logic arstN_i,
    tokenIf.controller tok,
    sendReqIf.controller snd,
    input logic epRespValid_i,
    input usbPePkg::pidT epRespPid_i,
    input logic epInAvail_i,
    output logic epOutCommit_o,
    output logic epOutAbort_o,
    output logic epInDone_o,
    output logic epInSuccess_o
);

    usbPePkg::ctrlStateT state;
    usbPePkg::timerT timer;
    logic timeout;
    logic isHandshakePid;
    // Set when the IN response was a lone handshake with no host reply to wait for
    logic handshakeOnly;

    assign timeout = timer == usbPePkg::timerT'(`USB_PE_TIMEOUT - 1);

    // ACK, NAK and STALL all end in binary 10 while DATA PIDs end in 11
    assign isHandshakePid = epRespPid_i[1:0] == 2'b10;

    // Route already from the token pulse so an early data PID is skipped too
    assign tok.dataPhase = (state == usbPePkg::OUT_DATA)
        || ((state == usbPePkg::IDLE) && tok.tokenValid && !tok.isIn);
    assign tok.respPhase = (state == usbPePkg::IN_SEND) || (state == usbPePkg::IN_AWAIT);

    // ==================================================
    // Wait timer
    // ==================================================

    // Runs only in the two states that wait for the host
    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            timer <= '0;
        end else if ((state == usbPePkg::OUT_DATA) || (state == usbPePkg::IN_AWAIT)) begin
            timer <= timer + 1'b1;
        end else begin
            timer <= '0;
        end
    end

    // ==================================================
    // Transaction FSM
    // ==================================================

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= usbPePkg::IDLE;
            snd.req <= 1'b0;
            snd.pid <= '0;
            snd.withData <= 1'b0;
            handshakeOnly <= 1'b0;
            epOutCommit_o <= 1'b0;
            epOutAbort_o <= 1'b0;
            epInDone_o <= 1'b0;
            epInSuccess_o <= 1'b0;
        end else begin
            // Endpoint strobes are single-cycle pulses
            epOutCommit_o <= 1'b0;
            epOutAbort_o <= 1'b0;
            epInDone_o <= 1'b0;
            epInSuccess_o <= 1'b0;
            case (state)
                usbPePkg::IDLE: begin
                    if (tok.tokenValid) begin
                        state <= tok.isIn ? usbPePkg::IN_RESPOND : usbPePkg::OUT_DATA;
                    end
                end
                usbPePkg::OUT_DATA: begin
                    if (tok.rxDone) begin
                        epOutCommit_o <= tok.rxSuccess;
                        epOutAbort_o <= !tok.rxSuccess;
                        // A broken packet gets no handshake at all
                        state <= tok.rxSuccess ? usbPePkg::OUT_RESPOND : usbPePkg::FINISH;
                    end else if (timeout) begin
                        epOutAbort_o <= 1'b1;
                        state <= usbPePkg::FINISH;
                    end
                end
                usbPePkg::OUT_RESPOND: begin
                    // The endpoint picks ACK, NAK or STALL
                    if (epRespValid_i) begin
                        snd.req <= 1'b1;
                        snd.pid <= epRespPid_i;
                        snd.withData <= 1'b0;
                        state <= usbPePkg::OUT_SEND;
                    end
                end
                usbPePkg::IN_RESPOND: begin
                    if (epRespValid_i) begin
                        snd.req <= 1'b1;
                        snd.pid <= epRespPid_i;
                        // A DATA PID without bytes behind it is a zero-length packet
                        snd.withData <= !isHandshakePid && epInAvail_i;
                        handshakeOnly <= isHandshakePid;
                        state <= usbPePkg::IN_SEND;
                    end
                end
                usbPePkg::OUT_SEND, usbPePkg::IN_SEND: begin
                    if (snd.ack) begin
                        snd.req <= 1'b0;
                        if (state == usbPePkg::IN_SEND && !handshakeOnly) begin
                            state <= usbPePkg::IN_AWAIT;
                        end else begin
                            epInDone_o <= state == usbPePkg::IN_SEND;
                            state <= usbPePkg::FINISH;
                        end
                    end
                end
                usbPePkg::IN_AWAIT: begin
                    // Only a good ACK from the host counts as delivered
                    if (tok.rxDone) begin
                        epInDone_o <= 1'b1;
                        epInSuccess_o <= tok.rxSuccess && (tok.rxPid == `PID_ACK);
                        state <= usbPePkg::FINISH;
                    end else if (timeout) begin
                        epInDone_o <= 1'b1;
                        state <= usbPePkg::FINISH;
                    end
                end
                usbPePkg::FINISH: begin
                    // Close the four-phase cycle before the next token
                    if (!snd.ack) begin
                        state <= usbPePkg::IDLE;
                    end
                end
                default: begin
                    state <= usbPePkg::IDLE;
                end
            endcase
        end
    end

    // A new request only starts once the previous ack has gone low
    reqAfterAckLow: assert property (@(posedge clk12_i) disable iff (!arstN_i)
        $rose(snd.req) |-> !$past(snd.ack));

    commitAbortExclusive: assert property (@(posedge clk12_i) disable iff (!arstN_i)
        !(epOutCommit_o && epOutAbort_o));

endmodule

//--- source/packetSender.sv
`timescale 1ns/1ps
`include "usbPe_defs.svh"

module packetSender (
    input logic clk12_i,
    input logic arstN_i,
    sendReqIf.sender snd,
    output usbPePkg::byteT txData_o,
    output logic txValid_o,
    output logic txLast_o,
    input logic txAccept_i,
    input usbPePkg::byteT epInData_i,
    input logic epInAvail_i,
    input logic epInLast_i,
    output logic epInPop_o
);

    // Exactly one of these is high while a packet goes out
    logic pidPhase;
    logic dataPhase;
    // Data bytes still allowed in this packet
    usbPePkg::byteCountT bytesLeft;
    logic txFire;

    // ==================================================
    // Byte selection
    // ==================================================

    // The PID goes out with its complement in the upper nibble
    assign txData_o = pidPhase ? {~snd.pid, snd.pid} : epInData_i;
    assign txValid_o = pidPhase || (dataPhase && epInAvail_i);

    // A packet ends at the PID when there is no data, else at the endpoint mark or the limit
    assign txLast_o = pidPhase ? !snd.withData
        : (dataPhase && (epInLast_i || (bytesLeft == usbPePkg::byteCountT'(1))));

    assign txFire = txValid_o && txAccept_i;

    // Each transferred data byte is taken out of the endpoint
    assign epInPop_o = dataPhase && epInAvail_i && txAccept_i;

    // ==================================================
    // Send sequence
    // ==================================================

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pidPhase <= 1'b0;
            dataPhase <= 1'b0;
            bytesLeft <= '0;
            snd.ack <= 1'b0;
        end else begin
            if (snd.req && !snd.ack && !pidPhase && !dataPhase) begin
                pidPhase <= 1'b1;
                bytesLeft <= usbPePkg::byteCountT'(`USB_PE_MAX_PACKET);
            end else if (pidPhase && txFire) begin
                pidPhase <= 1'b0;
                dataPhase <= snd.withData;
                snd.ack <= !snd.withData;
            end else if (dataPhase && txFire) begin
                bytesLeft <= bytesLeft - 1'b1;
                if (txLast_o) begin
                    dataPhase <= 1'b0;
                    snd.ack <= 1'b1;
                end
            end
            // Ack follows req down
            if (snd.ack && !snd.req) begin
                snd.ack <= 1'b0;
            end
        end
    end

    // The endpoint must hold its byte until it is popped
    txHoldStable: assert property (@(posedge clk12_i) disable iff (!arstN_i)
        (txValid_o && !txAccept_i) |=> (txValid_o && $stable(txData_o)));

endmodule

//--- source/usbProtocolEngine.sv
`timescale 1ns/1ps

module usbProtocolEngine (
    input logic clk12_i,
    input logic arstN_i,
    input usbPePkg::devAddrT devAddr_i,

    // Line receiver
    input usbPePkg::byteT rxData_i,
    input logic rxValid_i,
    input logic rxLast_i,
    input logic rxCrcOk_i,
    output logic rxAccept_o,

    // Line transmitter
    output usbPePkg::byteT txData_o,
    output logic txValid_o,
    output logic txLast_o,
    input logic txAccept_i,

    // The selected endpoint, valid from the token on
    output usbPePkg::epNumT epNum_o,

    // Endpoint receive side
    output usbPePkg::byteT epOutData_o,
    output logic epOutValid_o,
    input logic epOutFull_i,
    output logic epOutCommit_o,
    output logic epOutAbort_o,

    // Endpoint answer for the current transaction
    input logic epRespValid_i,
    input usbPePkg::pidT epRespPid_i,

    // Endpoint send side
    input usbPePkg::byteT epInData_i,
    input logic epInAvail_i,
    input logic epInLast_i,
    output logic epInPop_o,
    output logic epInDone_o,
    output logic epInSuccess_o
);

    tokenIf tokBus ();
    sendReqIf sendBus ();

    tokenReceiver rxPath (
        .clk12_i(clk12_i), .arstN_i(arstN_i), .devAddr_i(devAddr_i),
        .rxData_i(rxData_i), .rxValid_i(rxValid_i), .rxLast_i(rxLast_i),
        .rxCrcOk_i(rxCrcOk_i), .rxAccept_o(rxAccept_o), .epOutData_o(epOutData_o),
        .epOutValid_o(epOutValid_o), .epOutFull_i(epOutFull_i), .epNum_o(epNum_o),
        .tok(tokBus.receiver)
    );

    transactionCtrl ctrl (
        .clk12_i(clk12_i), .arstN_i(arstN_i), .tok(tokBus.controller),
        .snd(sendBus.controller), .epRespValid_i(epRespValid_i),
        .epRespPid_i(epRespPid_i), .epInAvail_i(epInAvail_i),
        .epOutCommit_o(epOutCommit_o), .epOutAbort_o(epOutAbort_o),
        .epInDone_o(epInDone_o), .epInSuccess_o(epInSuccess_o)
    );

    packetSender txPath (
        .clk12_i(clk12_i), .arstN_i(arstN_i), .snd(sendBus.sender),
        .txData_o(txData_o), .txValid_o(txValid_o), .txLast_o(txLast_o),
        .txAccept_i(txAccept_i), .epInData_i(epInData_i), .epInAvail_i(epInAvail_i),
        .epInLast_i(epInLast_i), .epInPop_o(epInPop_o)
    );

endmodule

//--- verif/tbUsbProtocolEngine.sv
`timescale 1ns/1ps
`include "usbPe_defs.svh"

module tbUsbProtocolEngine;

    localparam int NUM_SCENARIOS = 400;
    // Each scenario stays well below 300 cycles, even with both waits timing out
    localparam int CYCLE_LIMIT = NUM_SCENARIOS * 300;

    logic clk12_i, arstN_i;
    usbPePkg::devAddrT devAddr_i;
    usbPePkg::byteT rxData_i, txData_o, epOutData_o, epInData_i;
    logic rxValid_i, rxLast_i, rxCrcOk_i, rxAccept_o;
    logic txValid_o, txLast_o, txAccept_i;
    usbPePkg::epNumT epNum_o;
    logic epOutValid_o, epOutFull_i, epOutCommit_o, epOutAbort_o;
    logic epRespValid_i;
    usbPePkg::pidT epRespPid_i;
    logic epInAvail_i, epInLast_i, epInPop_o, epInDone_o, epInSuccess_o;

    integer seed;
    int cycleCount;
    int errorCount;
    // Bytes of the packet the host puts on the line next
    usbPePkg::byteT pktQ[$];
    // Endpoint IN data, the front byte is the one presented
    usbPePkg::byteT inQ[$];
    // What the DUT did in this scenario, and what the rules predict
    usbPePkg::byteT txQ[$], expTxQ[$], outQ[$], expOutQ[$];
    logic lastQ[$];
    int commitCnt, abortCnt, doneCnt;
    logic successSeen, rxTaken, popNow, txLastSeen;
    usbPePkg::epNumT expEp;

    usbProtocolEngine DUT (.*);

    // ==================================================
    // Clock and watchdog
    // ==================================================

    always #10 clk12_i = ~clk12_i;

    always @(posedge clk12_i) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: the scenarios did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "Watchdog expired");
        end
    end

    function automatic int randRange(input int n);
        randRange = $unsigned($random(seed)) % n;
    endfunction

    // The wire carries the PID in the low nibble and its complement above it
    function automatic usbPePkg::byteT pidByte(input usbPePkg::pidT pid);
        pidByte = {~pid, pid};
    endfunction

    task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
            errorCount++;
            $display("Finished with errors");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic compareQueue(input usbPePkg::byteT got[$], input usbPePkg::byteT exp[$],
                                input string what);
        int i;
        compareValue(got.size(), exp.size(), {what, " count"});
        for (i = 0; i < exp.size(); i++) begin
            compareValue(got[i], exp[i], what);
        end
    endtask

    // Endpoint IN side shows the front of its queue
    task automatic driveEndpoint();
        epInAvail_i = inQ.size() != 0;
        epInData_i = (inQ.size() != 0) ? inQ[0] : 8'h00;
        epInLast_i = inQ.size() == 1;
    endtask

    // ==================================================
    // One clock cycle with monitors and endpoint model
    // ==================================================

    // Outputs are sampled at the falling edge, inputs change 2 ns after the rising edge
    task automatic nextCycle();
        @(negedge clk12_i);
        rxTaken = rxValid_i && rxAccept_o;
        popNow = epInPop_o;
        if (txValid_o && txAccept_i) begin
            txQ.push_back(txData_o);
            lastQ.push_back(txLast_o);
            txLastSeen = txLastSeen || txLast_o;
        end
        if (epOutValid_o) begin
            outQ.push_back(epOutData_o);
            compareValue(epNum_o, expEp, "epNum_o with OUT data");
        end
        if (epOutCommit_o) commitCnt++;
        if (epOutAbort_o) abortCnt++;
        if (epInDone_o) begin
            doneCnt++;
            successSeen = epInSuccess_o;
            compareValue(epNum_o, expEp, "epNum_o at IN done");
        end
        @(posedge clk12_i);
        #2;
        if (popNow && inQ.size() != 0) begin
            void'(inQ.pop_front());
        end
        driveEndpoint();
        // Random transmitter stalls, about one cycle in four
        txAccept_i = randRange(4) != 0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) nextCycle();
    endtask

    task automatic clearRecords();
        txQ = {};
        expTxQ = {};
        outQ = {};
        expOutQ = {};
        lastQ = {};
        commitCnt = 0;
        abortCnt = 0;
        doneCnt = 0;
        successSeen = 1'b0;
        txLastSeen = 1'b0;
    endtask

    // ==================================================
    // Host model
    // ==================================================

    // Sends pktQ byte by byte, epOutFull_i may refuse data bytes for a while
    task automatic sendPacket(input logic crcOk, input logic fullAtLast, input logic stallFull);
        int i;
        for (i = 0; i < pktQ.size(); i++) begin
            idleCycles(randRange(3));
            rxData_i = pktQ[i];
            rxValid_i = 1'b1;
            rxLast_i = i == pktQ.size() - 1;
            rxCrcOk_i = crcOk;
            rxTaken = 1'b0;
            while (!rxTaken) begin
                epOutFull_i = rxLast_i ? fullAtLast : (stallFull && randRange(4) == 0);
                nextCycle();
            end
            rxValid_i = 1'b0;
            rxLast_i = 1'b0;
            epOutFull_i = 1'b0;
        end
    endtask

    task automatic sendToken(input usbPePkg::pidT pid, input usbPePkg::devAddrT addr,
                             input usbPePkg::epNumT ep);
        pktQ = {};
        pktQ.push_back(pidByte(pid));
        pktQ.push_back({ep[0], addr});
        // CRC5 bits are random, the line receiver reports the CRC result
        pktQ.push_back({5'(randRange(32)), ep[3:1]});
        sendPacket(1'b1, 1'b0, 1'b0);
    endtask

    // Compares all records of a scenario, then clears them
    task automatic endScenario(input int expCommit, input int expAbort, input int expDone,
                               input logic expSuccess);
        int i;
        idleCycles(12);
        compareQueue(txQ, expTxQ, "transmitted byte");
        for (i = 0; i < lastQ.size(); i++) begin
            compareValue(lastQ[i], i == lastQ.size() - 1, "txLast_o position");
        end
        compareQueue(outQ, expOutQ, "epOutData_o byte");
        compareValue(commitCnt, expCommit, "epOutCommit_o pulses");
        compareValue(abortCnt, expAbort, "epOutAbort_o pulses");
        compareValue(doneCnt, expDone, "epInDone_o pulses");
        if (expDone != 0) compareValue(successSeen, expSuccess, "epInSuccess_o");
        epRespValid_i = 1'b0;
        inQ = {};
        driveEndpoint();
        clearRecords();
    endtask

    // ==================================================
    // Scenarios
    // ==================================================

    task automatic runIgnored();
        int kind;
        kind = randRange(3);
        epRespValid_i = 1'b1;
        epRespPid_i = `PID_ACK;
        if (kind == 0) begin
            sendToken(randRange(2) ? `PID_OUT : `PID_IN,
                      devAddr_i ^ usbPePkg::devAddrT'(1 + randRange(127)), randRange(4));
        end else if (kind == 1) begin
            sendToken(`PID_SOF, devAddr_i, randRange(16));
        end else begin
            sendToken(randRange(2) ? `PID_OUT : `PID_IN, devAddr_i, 4 + randRange(12));
        end
        endScenario(0, 0, 0, 1'b0);
        // The endpoint selection of the last valid token must survive
        compareValue(epNum_o, expEp, "epNum_o after an ignored token");
    endtask

    task automatic runOut();
        usbPePkg::pidT respPid;
        int mode;
        int n;
        int i;
        expEp = randRange(`USB_PE_ENDPOINTS);
        case (randRange(3))
            0: respPid = `PID_ACK;
            1: respPid = `PID_NAK;
            default: respPid = `PID_STALL;
        endcase
        epRespPid_i = respPid;
        epRespValid_i = 1'b1;
        sendToken(randRange(2) ? `PID_OUT : `PID_SETUP, devAddr_i, expEp);
        // Mode 0 good, 1 bad CRC, 2 endpoint full at the last byte, 3 no data packet
        mode = randRange(4);
        n = randRange(`USB_PE_MAX_PACKET + 1);
        if (mode == 2 && n == 0) n = 1;
        if (mode != 3) begin
            pktQ = {};
            pktQ.push_back(pidByte(randRange(2) ? `PID_DATA1 : `PID_DATA0));
            for (i = 0; i < n; i++) pktQ.push_back(usbPePkg::byteT'(randRange(256)));
            // A last byte that meets a full endpoint never reaches it
            for (i = 0; i < ((mode == 2) ? n - 1 : n); i++) expOutQ.push_back(pktQ[i + 1]);
            sendPacket(mode != 1, mode == 2, 1'b1);
        end
        if (mode == 0) begin
            expTxQ.push_back(pidByte(respPid));
            while (!txLastSeen) nextCycle();
        end else begin
            while (abortCnt == 0) nextCycle();
        end
        endScenario(mode == 0, mode != 0, 0, 1'b0);
    endtask

    task automatic runIn();
        usbPePkg::pidT respPid;
        logic handshake;
        int n;
        int m;
        int i;
        int reply;
        expEp = randRange(`USB_PE_ENDPOINTS);
        n = randRange(`USB_PE_MAX_PACKET + 5);
        for (i = 0; i < n; i++) inQ.push_back(usbPePkg::byteT'(randRange(256)));
        driveEndpoint();
        handshake = randRange(3) == 0;
        if (handshake) respPid = randRange(2) ? `PID_NAK : `PID_STALL;
        else respPid = randRange(2) ? `PID_DATA1 : `PID_DATA0;
        // Data is cut at the packet limit, and a handshake carries none
        m = handshake ? 0 : ((n > `USB_PE_MAX_PACKET) ? `USB_PE_MAX_PACKET : n);
        expTxQ.push_back(pidByte(respPid));
        for (i = 0; i < m; i++) expTxQ.push_back(inQ[i]);
        epRespPid_i = respPid;
        epRespValid_i = 1'b1;
        sendToken(`PID_IN, devAddr_i, expEp);
        // Reply 0 good ACK, 1 NAK, 2 ACK with bad CRC, 3 silence
        reply = handshake ? 3 : randRange(4);
        if (!handshake) begin
            while (!txLastSeen) nextCycle();
            if (reply != 3) begin
                idleCycles(randRange(4));
                pktQ = {};
                pktQ.push_back(pidByte((reply == 1) ? `PID_NAK : `PID_ACK));
                sendPacket(reply != 2, 1'b0, 1'b0);
            end
        end
        while (doneCnt == 0) nextCycle();
        compareValue(inQ.size(), n - m, "endpoint bytes left after IN");
        endScenario(0, 0, 1, reply == 0);
    endtask

    initial begin
        int scen;
        int kind;
        seed = 34458;
        clk12_i = 1'b0;
        arstN_i = 1'b0;
        devAddr_i = '0;
        rxData_i = '0;
        rxValid_i = 1'b0;
        rxLast_i = 1'b0;
        rxCrcOk_i = 1'b0;
        txAccept_i = 1'b0;
        epOutFull_i = 1'b0;
        epRespValid_i = 1'b0;
        epRespPid_i = '0;
        epInData_i = '0;
        epInAvail_i = 1'b0;
        epInLast_i = 1'b0;
        cycleCount = 0;
        errorCount = 0;
        expEp = '0;
        clearRecords();
        repeat (10) @(posedge clk12_i);
        #2;
        // Only rxAccept_o is high while the engine sits in reset
        compareValue({txValid_o, epOutValid_o, epOutCommit_o, epOutAbort_o, epInPop_o,
                      epInDone_o, epInSuccess_o, rxAccept_o}, 8'h01, "outputs in reset");
        arstN_i = 1'b1;
        for (scen = 0; scen < NUM_SCENARIOS; scen++) begin
            devAddr_i = usbPePkg::devAddrT'(randRange(128));
            kind = randRange(10);
            if (kind < 2) runIgnored();
            else if (kind < 6) runOut();
            else runIn();
        end
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/usbPePkg.sv
source/tokenIf.sv
source/sendReqIf.sv
source/tokenReceiver.sv
source/transactionCtrl.sv
source/packetSender.sv
source/usbProtocolEngine.sv
verif/tbUsbProtocolEngine.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbUsbProtocolEngine \
    -f project.f -o simUsbPe > build.log 2>&1 \
    && ./obj_dir/simUsbPe > sim.log 2>&1 \
    || { echo "Build or simulation stopped early, see build.log and sim.log"; exit 1; }
grep -q "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
